/* include/riscv_defs.svh */
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

`define XLEN        32
`define RESET_PC    32'h0000_0000
`define IMEM_DEPTH  256
`define IMEM_AW     8
`define DMEM_DEPTH  64
`define DMEM_AW     6

// major opcodes, instr[6:0]
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_SYSTEM  7'b1110011

`define F3_CSRRW    3'b001
`define F3_SR       3'b101
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define CSR_TOHOST  12'h51e
`define NOP_INSTR   32'h0000_0013

// alu op is {instr[30], funct3}, pass-b uses a free code
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b1000
`define ALU_SLL     4'b0001
`define ALU_SLT     4'b0010
`define ALU_SLTU    4'b0011
`define ALU_XOR     4'b0100
`define ALU_SRL     4'b0101
`define ALU_SRA     4'b1101
`define ALU_OR      4'b0110
`define ALU_AND     4'b0111
`define ALU_PASSB   4'b1111

`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_PC4      2'd2
`define WB_NONE     2'd3

`endif

/* logic/riscv_pkg.sv */
`include "riscv_defs.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0]    word_t;      // data, address, instruction
    typedef logic [4:0]          reg_addr_t;
    typedef logic [`IMEM_AW-1:0] imem_addr_t; // word index for program load
    typedef logic [`DMEM_AW-1:0] dmem_addr_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [3:0]          alu_op_t;
    typedef logic [1:0]          wb_sel_t;

    // execute to writeback register contents
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        wb_sel_t   wb_sel;
        word_t     alu;      // also carries the csr write value
        word_t     pc_plus4;
    } ex_wb_t;

endpackage

/* logic/id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if;
    import riscv_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     pc_plus4;
    reg_addr_t rs1;
    word_t     rs1_data;
    reg_addr_t rs2;
    word_t     rs2_data;
    reg_addr_t rd;
    word_t     imm;
    alu_op_t   alu_op;
    logic      a_is_pc;  // alu operand a from pc instead of rs1
    logic      b_is_imm; // alu operand b from imm instead of rs2
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    funct3_t   funct3;
    logic      mem_write;
    logic      is_csr_write;
    wb_sel_t   wb_sel;

    modport producer (output valid, pc, pc_plus4, rs1, rs1_data, rs2, rs2_data, rd, imm,
                      alu_op, a_is_pc, b_is_imm, is_branch, is_jal, is_jalr, funct3,
                      mem_write, is_csr_write, wb_sel);
    modport consumer (input valid, pc, pc_plus4, rs1, rs1_data, rs2, rs2_data, rd, imm,
                      alu_op, a_is_pc, b_is_imm, is_branch, is_jal, is_jalr, funct3,
                      mem_write, is_csr_write, wb_sel);

endinterface

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`include "riscv_defs.svh"

module fetch_stage (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   imem_we_i,
    input  riscv_pkg::imem_addr_t  imem_addr_i,
    input  riscv_pkg::word_t       imem_wdata_i,
    input  logic                   redirect_i,
    input  riscv_pkg::word_t       target_i,
    output riscv_pkg::word_t       instr_o,
    output riscv_pkg::word_t       pc_o,
    output logic                   instr_valid_o
);
    import riscv_pkg::*;

    word_t pc_q;     // pc of the word in instr_q
    word_t instr_q;
    logic  valid_q;
    word_t fetch_pc;
    word_t next_pc;
    word_t imem [`IMEM_DEPTH];

    // after a bubble the same pc is read again
    assign fetch_pc = valid_q ? pc_q + 32'd4 : pc_q;
    assign next_pc  = redirect_i ? target_i : fetch_pc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= next_pc;
            valid_q <= ~redirect_i; // target word shows up one cycle late
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i && imem_we_i)
            imem[imem_addr_i] <= imem_wdata_i; // program load port
        instr_q <= imem[next_pc[`IMEM_AW+1:2]];
    end

    assign instr_o       = valid_q ? instr_q : `NOP_INSTR;
    assign pc_o          = pc_q;
    assign instr_valid_o = valid_q;

    // program may only be written with the core held in reset
    a_load_in_reset: assert property (@(posedge clk_i) imem_we_i |-> rst_i);

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                  clk_i,
    input  riscv_pkg::reg_addr_t  rs1_i,
    input  riscv_pkg::reg_addr_t  rs2_i,
    output riscv_pkg::word_t      rs1_data_o,
    output riscv_pkg::word_t      rs2_data_o,
    input  logic                  we_i,
    input  riscv_pkg::reg_addr_t  rd_i,
    input  riscv_pkg::word_t      rd_data_i
);
    import riscv_pkg::*;

    word_t regs [32];

    // x0 reads zero and a same-cycle write is bypassed
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        else if (we_i && rd_i == addr)
            return rd_data_i;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk_i) begin
        if (we_i && rd_i != 5'd0)
            regs[rd_i] <= rd_data_i;
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`include "riscv_defs.svh"

module decode_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  riscv_pkg::word_t      instr_i,
    input  riscv_pkg::word_t      pc_i,
    input  logic                  instr_valid_i,
    input  logic                  redirect_i,
    output riscv_pkg::reg_addr_t  rs1_o,
    output riscv_pkg::reg_addr_t  rs2_o,
    input  riscv_pkg::word_t      rs1_data_i,
    input  riscv_pkg::word_t      rs2_data_i,
    id_ex_if.producer             ex
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    reg_addr_t  rd;
    funct3_t    funct3;
    word_t      imm;
    alu_op_t    alu_op;
    logic       a_is_pc;
    logic       b_is_imm;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       mem_write;
    logic       is_csr_write;
    wb_sel_t    wb_sel;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    always_comb begin
        imm          = '0;
        alu_op       = `ALU_ADD;
        a_is_pc      = 1'b0;
        b_is_imm     = 1'b1;
        is_branch    = 1'b0;
        is_jal       = 1'b0;
        is_jalr      = 1'b0;
        mem_write    = 1'b0;
        is_csr_write = 1'b0;
        wb_sel       = `WB_NONE; // unknown opcodes retire as no-op
        case (opcode)
            `OPC_OP: begin
                alu_op   = {instr_i[30], funct3};
                b_is_imm = 1'b0;
                wb_sel   = `WB_ALU;
            end
            `OPC_OP_IMM: begin
                imm    = {{20{instr_i[31]}}, instr_i[31:20]};
                alu_op = {instr_i[30] & (funct3 == `F3_SR), funct3}; // only srai has bit 30
                wb_sel = `WB_ALU;
            end
            `OPC_LUI: begin
                imm    = {instr_i[31:12], 12'b0};
                alu_op = `ALU_PASSB;
                wb_sel = `WB_ALU;
            end
            `OPC_AUIPC: begin
                imm     = {instr_i[31:12], 12'b0};
                a_is_pc = 1'b1;
                wb_sel  = `WB_ALU;
            end
            `OPC_LOAD: begin
                imm    = {{20{instr_i[31]}}, instr_i[31:20]};
                wb_sel = `WB_MEM; // always a full word
            end
            `OPC_STORE: begin
                imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                mem_write = 1'b1;
            end
            `OPC_BRANCH: begin
                imm       = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
                is_branch = 1'b1;
            end
            `OPC_JAL: begin
                imm    = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                          instr_i[30:21], 1'b0};
                is_jal = 1'b1;
                wb_sel = `WB_PC4;
            end
            `OPC_JALR: begin
                imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                is_jalr = 1'b1;
                wb_sel  = `WB_PC4;
            end
            `OPC_SYSTEM: begin
                // csrw to tohost, rs1 + 0 passes through the alu
                is_csr_write = (funct3 == `F3_CSRRW) && (instr_i[31:20] == `CSR_TOHOST);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || redirect_i)
            ex.valid <= 1'b0; // squash wrong-path instruction
        else
            ex.valid <= instr_valid_i;
        ex.pc           <= pc_i;
        ex.pc_plus4     <= pc_i + 32'd4;
        ex.rs1          <= rs1_o;
        ex.rs1_data     <= rs1_data_i;
        ex.rs2          <= rs2_o;
        ex.rs2_data     <= rs2_data_i;
        ex.rd           <= rd;
        ex.imm          <= imm;
        ex.alu_op       <= alu_op;
        ex.a_is_pc      <= a_is_pc;
        ex.b_is_imm     <= b_is_imm;
        ex.is_branch    <= is_branch;
        ex.is_jal       <= is_jal;
        ex.is_jalr      <= is_jalr;
        ex.funct3       <= funct3;
        ex.mem_write    <= mem_write;
        ex.is_csr_write <= is_csr_write;
        ex.wb_sel       <= wb_sel;
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`include "riscv_defs.svh"

module execute_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    id_ex_if.consumer             id,
    input  logic                  wb_we_i,
    input  riscv_pkg::reg_addr_t  wb_rd_i,
    input  riscv_pkg::word_t      wb_data_i,
    output logic                  redirect_o,
    output riscv_pkg::word_t      target_o,
    output riscv_pkg::dmem_addr_t dmem_addr_o,
    output riscv_pkg::word_t      dmem_wdata_o,
    output logic                  dmem_we_o,
    output riscv_pkg::ex_wb_t     ex_wb_o,
    output logic                  csr_write_o
);
    import riscv_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    logic  taken;

    // forwarding from writeback also covers load-use
    assign rs1_val = (wb_we_i && wb_rd_i != 5'd0 && wb_rd_i == id.rs1) ? wb_data_i : id.rs1_data;
    assign rs2_val = (wb_we_i && wb_rd_i != 5'd0 && wb_rd_i == id.rs2) ? wb_data_i : id.rs2_data;

    assign op_a = id.a_is_pc  ? id.pc  : rs1_val;
    assign op_b = id.b_is_imm ? id.imm : rs2_val;

    always_comb begin
        case (id.alu_op)
            `ALU_SUB:   alu_res = op_a - op_b;
            `ALU_SLL:   alu_res = op_a << op_b[4:0];
            `ALU_SLT:   alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU:  alu_res = {31'b0, op_a < op_b};
            `ALU_XOR:   alu_res = op_a ^ op_b;
            `ALU_SRL:   alu_res = op_a >> op_b[4:0];
            `ALU_SRA:   alu_res = $signed(op_a) >>> op_b[4:0];
            `ALU_OR:    alu_res = op_a | op_b;
            `ALU_AND:   alu_res = op_a & op_b;
            `ALU_PASSB: alu_res = op_b;           // lui
            default:    alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (id.funct3)
            `F3_BEQ:  taken = rs1_val == rs2_val;
            `F3_BNE:  taken = rs1_val != rs2_val;
            `F3_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
            `F3_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
            `F3_BLTU: taken = rs1_val < rs2_val;
            `F3_BGEU: taken = rs1_val >= rs2_val;
            default:  taken = 1'b0;
        endcase
    end

    assign redirect_o = id.valid && (id.is_jal || id.is_jalr || (id.is_branch && taken));
    assign target_o   = id.is_jalr ? {alu_res[31:1], 1'b0} : id.pc + id.imm;

    // data memory is addressed straight from EX
    assign dmem_addr_o  = alu_res[`DMEM_AW+1:2];
    assign dmem_wdata_o = rs2_val;
    assign dmem_we_o    = id.valid && id.mem_write;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_wb_o.valid <= 1'b0;
            csr_write_o   <= 1'b0;
        end else begin
            ex_wb_o.valid <= id.valid;
            csr_write_o   <= id.valid && id.is_csr_write;
        end
        ex_wb_o.rd       <= id.rd;
        ex_wb_o.wb_sel   <= id.wb_sel;
        ex_wb_o.alu      <= alu_res;
        ex_wb_o.pc_plus4 <= id.pc_plus4;
    end

    // flush plus fetch bubble give two empty EX slots
    a_two_bubbles: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_o |=> !id.valid ##1 !id.valid);

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/1ps
`include "riscv_defs.svh"

module writeback_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  riscv_pkg::ex_wb_t     ex_wb_i,
    input  riscv_pkg::dmem_addr_t dmem_addr_i,
    input  riscv_pkg::word_t      dmem_wdata_i,
    input  logic                  dmem_we_i,
    input  logic                  csr_write_i,
    output logic                  rf_we_o,
    output riscv_pkg::reg_addr_t  rf_rd_o,
    output riscv_pkg::word_t      rf_data_o,
    output riscv_pkg::word_t      csr_o
);
    import riscv_pkg::*;

    word_t dmem [`DMEM_DEPTH];
    word_t load_data; // valid in the WB cycle of the load
    word_t csr_q;

    always_ff @(posedge clk_i) begin
        if (dmem_we_i)
            dmem[dmem_addr_i] <= dmem_wdata_i;
        load_data <= dmem[dmem_addr_i];
    end

    always_comb begin
        case (ex_wb_i.wb_sel)
            `WB_MEM: rf_data_o = load_data;
            `WB_PC4: rf_data_o = ex_wb_i.pc_plus4; // link value
            default: rf_data_o = ex_wb_i.alu;
        endcase
    end

    assign rf_we_o = ex_wb_i.valid && ex_wb_i.rd != 5'd0 && ex_wb_i.wb_sel != `WB_NONE;
    assign rf_rd_o = ex_wb_i.rd;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            csr_q <= '0;
        else if (csr_write_i)
            csr_q <= ex_wb_i.alu; // rs1 value passed through EX
    end

    assign csr_o = csr_q;

endmodule

/* logic/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  imem_we_i,
    input  riscv_pkg::imem_addr_t imem_addr_i,
    input  riscv_pkg::word_t      imem_wdata_i,
    output logic                  retire_valid_o,
    output riscv_pkg::reg_addr_t  retire_rd_o,
    output riscv_pkg::word_t      retire_data_o,
    output riscv_pkg::word_t      csr_o
);
    import riscv_pkg::*;

    word_t      instr;
    word_t      pc;
    logic       instr_valid;
    logic       redirect;
    word_t      target;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    dmem_addr_t dmem_addr;
    word_t      dmem_wdata;
    logic       dmem_we;
    ex_wb_t     ex_wb;
    logic       csr_write;
    logic       rf_we;
    reg_addr_t  rf_rd;
    word_t      rf_data;

    id_ex_if id_ex ();

    fetch_stage fetch_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .redirect_i(redirect), .target_i(target),
        .instr_o(instr), .pc_o(pc), .instr_valid_o(instr_valid)
    );

    decode_stage decode_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_i(instr), .pc_i(pc), .instr_valid_i(instr_valid),
        .redirect_i(redirect),
        .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex(id_ex.producer)
    );

    regfile regfile_i (
        .clk_i(clk_i),
        .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .rd_i(rf_rd), .rd_data_i(rf_data)
    );

    execute_stage execute_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .id(id_ex.consumer),
        .wb_we_i(rf_we), .wb_rd_i(rf_rd), .wb_data_i(rf_data), // forwarding path
        .redirect_o(redirect), .target_o(target),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_we_o(dmem_we),
        .ex_wb_o(ex_wb), .csr_write_o(csr_write)
    );

    writeback_stage writeback_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .ex_wb_i(ex_wb),
        .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata), .dmem_we_i(dmem_we),
        .csr_write_i(csr_write),
        .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_data_o(rf_data),
        .csr_o(csr_o)
    );

    // every register write is a retire event
    assign retire_valid_o = rf_we;
    assign retire_rd_o    = rf_rd;
    assign retire_data_o  = rf_data;

endmodule

/* verification/riscv_tb.sv */
`timescale 1ns/1ps
`include "riscv_defs.svh"

module riscv_tb;
    import riscv_pkg::*;

    localparam int    NUM_PROGS      = 4;
    localparam int    PROG_LEN       = 64;
    localparam int    BODY_START     = 15;   // after register and data memory setup
    localparam int    TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 4 + 50);
    localparam word_t HALT           = 32'h0000_006f; // jal x0, 0

    logic       clk_i;
    logic       rst_i;
    logic       imem_we_i;
    imem_addr_t imem_addr_i;
    word_t      imem_wdata_i;
    logic       retire_valid_o;
    reg_addr_t  retire_rd_o;
    word_t      retire_data_o;
    word_t      csr_o;
    logic       rst_q = 1'b0; // reset as seen by the DUT at the last edge

    word_t      prog [PROG_LEN];
    word_t      m_regs [32];
    word_t      m_mem [`DMEM_DEPTH];
    reg_addr_t  exp_rd_q [$];
    word_t      exp_data_q [$];
    word_t      exp_csr;

    riscv_core dut_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .csr_o(csr_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) rst_q <= rst_i;

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            $display("FAILED at time %0t: retired rd is x%0d, expected x%0d", $time, got, want);
            abort_run();
        end
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input funct3_t f3,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    // rv32i integer semantics, alt selects sub and sra
    function automatic word_t alu_result(input funct3_t f3, input logic alt,
                                         input word_t a, input word_t b);
        word_t res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return $signed(a) < $signed(b);
            `F3_BGE:  return $signed(a) >= $signed(b);
            `F3_BLTU: return a < b;
            `F3_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic make_program();
        int          tgt;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        funct3_t     f3;
        logic [6:0]  f7;
        logic [11:0] imm;

        for (int r = 1; r < 8; r++)
            prog[r - 1] = i_type(12'($urandom), 5'd0, 3'b000, reg_addr_t'(r), `OPC_OP_IMM);
        // every data word the body touches gets a known value
        for (int k = 0; k < 8; k++)
            prog[7 + k] = s_type(12'(k * 4), reg_addr_t'(k % 7 + 1), 5'd0);
        for (int i = BODY_START; i < PROG_LEN - 1; i++) begin
            rd  = reg_addr_t'($urandom_range(7, 0)); // few registers, many dependencies
            rs1 = reg_addr_t'($urandom_range(7, 0));
            rs2 = reg_addr_t'($urandom_range(7, 0));
            f3  = funct3_t'($urandom_range(7, 0));
            tgt = i + 1 + int'($urandom_range(5, 0));
            if (tgt > PROG_LEN - 1)
                tgt = PROG_LEN - 1; // forward only, at most to halt
            case ($urandom_range(11, 0))
                0, 1, 2: begin
                    f7 = ((f3 == 3'b000 || f3 == `F3_SR) && $urandom_range(1, 0) == 1) ?
                         7'h20 : 7'h00;
                    prog[i] = r_type(f7, rs2, rs1, f3, rd);
                end
                3, 4, 5: begin
                    if (f3 == 3'b001)
                        imm = {7'h00, 5'($urandom)};
                    else if (f3 == `F3_SR)
                        imm = {($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00, 5'($urandom)};
                    else
                        imm = 12'($urandom);
                    prog[i] = i_type(imm, rs1, f3, rd, `OPC_OP_IMM);
                end
                6: prog[i] = u_type(20'($urandom), rd,
                                    ($urandom_range(1, 0) == 1) ? `OPC_LUI : `OPC_AUIPC);
                7: prog[i] = s_type(12'($urandom_range(7, 0) * 4), rs2, 5'd0);
                8: prog[i] = i_type(12'($urandom_range(7, 0) * 4), 5'd0, 3'b010, rd, `OPC_LOAD);
                9: begin
                    f3 = funct3_t'($urandom_range(5, 0));
                    if (f3 >= 3'd2)
                        f3 = f3 + 3'd2; // skip the two unused codes
                    prog[i] = b_type(13'((tgt - i) * 4), f3, rs1, rs2);
                end
                10: begin
                    if ($urandom_range(1, 0) == 1)
                        prog[i] = j_type(21'((tgt - i) * 4), rd);
                    else
                        prog[i] = i_type(12'(tgt * 4), 5'd0, 3'b000, rd, `OPC_JALR);
                end
                default: prog[i] = i_type(`CSR_TOHOST, rs1, `F3_CSRRW, 5'd0, `OPC_SYSTEM);
            endcase
        end
        prog[PROG_LEN - 1] = HALT;
    endtask

    // instruction-set model, fills the expected write list
    task automatic run_model();
        word_t     pc;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_j;
        word_t     addr;
        word_t     res;
        word_t     next_pc;
        logic      wr;
        reg_addr_t rd;
        funct3_t   f3;

        exp_rd_q.delete();
        exp_data_q.delete();
        exp_csr = '0;
        for (int r = 0; r < 32; r++)
            m_regs[r] = '0;
        pc  = `RESET_PC;
        ins = prog[pc[7:2]];
        while (ins != HALT) begin
            rd      = ins[11:7];
            f3      = ins[14:12];
            a       = m_regs[ins[19:15]];
            b       = m_regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            case (ins[6:0])
                `OPC_OP: begin
                    res = alu_result(f3, ins[30], a, b);
                    wr  = 1'b1;
                end
                `OPC_OP_IMM: begin
                    res = alu_result(f3, ins[30] && f3 == `F3_SR, a, imm_i);
                    wr  = 1'b1;
                end
                `OPC_LUI: begin
                    res = {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                `OPC_AUIPC: begin
                    res = pc + {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                `OPC_LOAD: begin
                    addr = a + imm_i;
                    res  = m_mem[addr[`DMEM_AW+1:2]];
                    wr   = 1'b1;
                end
                `OPC_STORE: begin
                    addr = a + imm_s;
                    m_mem[addr[`DMEM_AW+1:2]] = b;
                end
                `OPC_BRANCH: begin
                    if (branch_taken(f3, a, b))
                        next_pc = pc + imm_b;
                end
                `OPC_JAL: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = pc + imm_j;
                end
                `OPC_JALR: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                `OPC_SYSTEM: begin
                    if (f3 == `F3_CSRRW && ins[31:20] == `CSR_TOHOST)
                        exp_csr = a;
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                m_regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
            end
            pc  = next_pc;
            ins = prog[pc[7:2]];
        end
    endtask

    // retire monitor, outputs settle well before the falling edge
    always @(negedge clk_i) begin
        if (rst_i && rst_q) begin
            if (retire_valid_o) begin
                $display("retire strobe seen while the core is held in reset");
                abort_run();
            end
            check_word(csr_o, '0, "csr_o in reset");
        end else if (!rst_i && retire_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("register write retired after the program should have halted");
                abort_run();
            end
            check_reg(retire_rd_o, exp_rd_q.pop_front());
            check_word(retire_data_o, exp_data_q.pop_front(), "retired data");
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout: the core did not reach halt within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        void'($urandom(32'h90e5_7e9f));
        for (int p = 0; p < NUM_PROGS; p++) begin
            make_program();
            run_model();
            @(posedge clk_i);
            rst_i <= 1'b1;
            repeat (8) @(posedge clk_i);
            for (int w = 0; w < PROG_LEN; w++) begin // load while still in reset
                imem_we_i    <= 1'b1;
                imem_addr_i  <= imem_addr_t'(w);
                imem_wdata_i <= prog[w];
                @(posedge clk_i);
            end
            imem_we_i <= 1'b0;
            rst_i     <= 1'b0;
            while (exp_rd_q.size() != 0)
                @(posedge clk_i);
            repeat (20) @(negedge clk_i); // any extra retire fails in the monitor
            check_word(csr_o, exp_csr, "csr_o at halt");
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
logic/riscv_pkg.sv
logic/id_ex_if.sv
logic/fetch_stage.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/riscv_core.sv
verification/riscv_tb.sv

/* Makefile */
RTL_SRCS := $(filter logic/%.sv,$(shell cat compile.f))

.PHONY: all lint clean

all: obj_dir/Vriscv_tb
	./obj_dir/Vriscv_tb

obj_dir/Vriscv_tb: compile.f include/riscv_defs.svh $(RTL_SRCS) verification/riscv_tb.sv
	verilator --binary --timing --assert --top-module riscv_tb -f compile.f

lint:
	verilator --lint-only -Wall +incdir+include --top-module riscv_core $(RTL_SRCS)

clean:
	rm -rf obj_dir
